// File: common/emu_config.svh
// emulator sizes and fixed addresses
`ifndef EMU_CONFIG_SVH
`define EMU_CONFIG_SVH

`define EMU_NE            4
`define EMU_EA_W          2    // endpoint index
`define EMU_RAM_AW        5    // pattern RAM depth 32
`define EMU_PCK_CNT_W     16
`define EMU_RATIO_W       7    // enough for 100
`define EMU_MAX_RATIO     100
`define EMU_PCK_SIZ_W     8
`define EMU_CLASS_W       2
`define EMU_TIME_W        24
`define EMU_STAT_W        32

// delay from start pulse to first sequencer step
`define EMU_START_DELAY   12

`define EMU_REPEAT_ADDR   0    // word 0 holds the pass repeat count
`define EMU_PATTERN_START 1

`endif

// File: common/emu_pkg.sv
// emulator shared types
`include "emu_config.svh"

package emu_pkg;

    // one pattern RAM word
    // pck_num doubles as repeat count in word 0
    typedef struct packed {
        logic [`EMU_PCK_CNT_W-1:0] pck_num;
        logic [`EMU_RATIO_W-1:0]   ratio;     // percent
        logic [`EMU_PCK_SIZ_W-1:0] pck_size;  // flits
        logic [`EMU_EA_W-1:0]      dest;
        logic [`EMU_CLASS_W-1:0]   pck_class;
        logic                      last;
    } pattern_entry_t;

    typedef struct packed {
        logic [`EMU_EA_W-1:0]   ep;
        logic [`EMU_RAM_AW-1:0] addr;
        pattern_entry_t         data;
    } host_wr_t;

    typedef struct packed {
        logic [`EMU_EA_W-1:0]      src;
        logic [`EMU_EA_W-1:0]      dest;
        logic [`EMU_CLASS_W-1:0]   pck_class;
        logic [`EMU_PCK_SIZ_W-1:0] pck_size;
        logic [`EMU_TIME_W-1:0]    time_stamp;  // injection time
    } pck_desc_t;

    typedef struct packed {
        logic [`EMU_EA_W-1:0]   dest;        // receiving endpoint
        logic [`EMU_TIME_W-1:0] time_stamp;  // stamp carried from injection
    } delivery_t;

    typedef enum logic [1:0] {
        STAT_SENT,
        STAT_RCVD,
        STAT_TOTAL_LAT,
        STAT_WORST_LAT
    } stat_id_e;

    typedef struct packed {
        logic [`EMU_EA_W-1:0] ep;
        stat_id_e             stat_id;
    } stat_sel_t;

    typedef enum logic [2:0] {IDLE, WAIT1, WAIT2, SEND, DONE} seq_state_e;

endpackage

// File: traffic_gen/pattern_ram.sv
// endpoint pattern memory
`timescale 1ns/1ps
`include "emu_config.svh"

module pattern_ram (
    input  logic                       clk,
    // host side
    input  logic                       wr_en_i,
    input  logic [`EMU_RAM_AW-1:0]     wr_addr_i,
    input  emu_pkg::pattern_entry_t    wr_data_i,
    // sequencer side
    input  logic [`EMU_RAM_AW-1:0]     rd_addr_i,
    output emu_pkg::pattern_entry_t    rd_data_o
);

    localparam int DEPTH = 2 ** `EMU_RAM_AW;

    emu_pkg::pattern_entry_t mem [DEPTH];

    always_ff @(posedge clk) begin
        if (wr_en_i) begin
            mem[wr_addr_i] <= wr_data_i;
        end
    end

    // one cycle read latency
    always_ff @(posedge clk) begin
        rd_data_o <= mem[rd_addr_i];
    end

endmodule

// File: traffic_gen/pattern_sequencer.sv
// pattern entry sequencer
`timescale 1ns/1ps
`include "emu_config.svh"

module pattern_sequencer (
    input  logic                       clk,
    input  logic                       reset,
    input  logic                       start_i,
    input  logic [`EMU_EA_W-1:0]       ep_addr_i,
    output logic [`EMU_RAM_AW-1:0]     rd_addr_o,
    input  emu_pkg::pattern_entry_t    entry_i,
    input  logic                       pck_sent_i,
    output logic                       inject_en_o,
    output emu_pkg::pattern_entry_t    entry_o,
    output logic                       stop_o,
    output logic                       done_o
);

    emu_pkg::seq_state_e       state;
    logic [`EMU_RAM_AW-1:0]    rd_addr;
    logic [`EMU_PCK_CNT_W-1:0] sent_cnt;
    logic [`EMU_PCK_CNT_W-1:0] sent_next;
    logic [`EMU_PCK_CNT_W-1:0] repeat_cnt;
    logic                      skip;       // entry targets this endpoint
    logic                      entry_end;
    logic                      done;

    assign sent_next = sent_cnt + `EMU_PCK_CNT_W'(pck_sent_i);
    assign entry_end = skip || (sent_next == entry_i.pck_num);

    assign rd_addr_o   = rd_addr;
    assign entry_o     = entry_i;
    assign stop_o      = (state == emu_pkg::DONE);
    assign done_o      = done;
    // hold off once the entry count is reached
    assign inject_en_o = (state == emu_pkg::SEND) && !skip &&
                         (sent_cnt != entry_i.pck_num);

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            state      <= emu_pkg::IDLE;
            rd_addr    <= `EMU_RAM_AW'(`EMU_REPEAT_ADDR);
            sent_cnt   <= '0;
            repeat_cnt <= '0;
            skip       <= 1'b0;
            done       <= 1'b0;
        end else begin
            // RAM data is fresh from WAIT2 on
            skip <= ((state == emu_pkg::WAIT2) || (state == emu_pkg::SEND)) &&
                    (entry_i.dest == ep_addr_i);
            case (state)
                emu_pkg::IDLE, emu_pkg::DONE: begin
                    rd_addr    <= `EMU_RAM_AW'(`EMU_REPEAT_ADDR);
                    repeat_cnt <= entry_i.pck_num;   // word 0 read back
                    if (start_i) begin
                        rd_addr  <= `EMU_RAM_AW'(`EMU_PATTERN_START);
                        sent_cnt <= '0;
                        done     <= 1'b0;
                        state    <= emu_pkg::WAIT1;
                    end
                end
                emu_pkg::WAIT1: begin
                    state <= emu_pkg::WAIT2;
                end
                emu_pkg::WAIT2: begin
                    state <= emu_pkg::SEND;
                end
                emu_pkg::SEND: begin
                    sent_cnt <= sent_next;
                    if (entry_end) begin
                        sent_cnt <= '0;
                        state    <= emu_pkg::WAIT1;    // two cycles for the next read
                        if (!entry_i.last) begin
                            rd_addr <= rd_addr + 1'b1;
                        end else if (repeat_cnt == '0) begin
                            rd_addr <= `EMU_RAM_AW'(`EMU_REPEAT_ADDR);
                            done    <= 1'b1;
                            state   <= emu_pkg::DONE;
                        end else begin
                            repeat_cnt <= repeat_cnt - 1'b1;
                            rd_addr    <= `EMU_RAM_AW'(`EMU_PATTERN_START);
                        end
                    end
                end
                default: state <= emu_pkg::IDLE;
            endcase
        end
    end

    // the repeat word is never treated as a pattern entry
    a_send_addr: assert property (@(posedge clk) disable iff (reset)
        (state == emu_pkg::SEND) |-> (rd_addr != `EMU_RAM_AW'(`EMU_REPEAT_ADDR)));

    a_done_stop: assert property (@(posedge clk) disable iff (reset)
        done_o |-> stop_o);

endmodule

// File: traffic_gen/packet_injector.sv
// ratio paced packet injector
`timescale 1ns/1ps
`include "emu_config.svh"

module packet_injector (
    input  logic                       clk,
    input  logic                       reset,
    input  logic [`EMU_EA_W-1:0]       ep_addr_i,
    input  logic                       inject_en_i,
    input  logic                       stop_i,
    input  emu_pkg::pattern_entry_t    entry_i,
    input  logic [`EMU_TIME_W-1:0]     time_i,
    output logic                       pck_valid_o,
    output emu_pkg::pck_desc_t         pck_o,
    output logic                       pck_sent_o
);

    logic [`EMU_RATIO_W:0]     credit;     // one extra bit for the sum
    logic [`EMU_RATIO_W:0]     credit_sum;
    logic [`EMU_PCK_SIZ_W-1:0] flit_cnt;   // flits left after the head
    logic                      busy;
    logic                      launch;

    assign credit_sum = credit + {1'b0, entry_i.ratio};
    assign busy       = (flit_cnt != '0);
    assign launch     = inject_en_i && !busy &&
                        (credit_sum >= (`EMU_RATIO_W + 1)'(`EMU_MAX_RATIO));

    // head cycle descriptor stamped with the current time
    assign pck_valid_o     = launch;
    assign pck_o.src       = ep_addr_i;
    assign pck_o.dest      = entry_i.dest;
    assign pck_o.pck_class = entry_i.pck_class;
    assign pck_o.pck_size  = entry_i.pck_size;
    assign pck_o.time_stamp = time_i;

    // tail pulse lands on the head cycle for single flit packets
    assign pck_sent_o = (launch && (entry_i.pck_size <= 1)) || (flit_cnt == 1);

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            credit   <= '0;
            flit_cnt <= '0;
        end else begin
            if (stop_i) begin
                credit <= '0;
            end else if (inject_en_i && !busy) begin
                credit <= launch ? credit_sum - (`EMU_RATIO_W + 1)'(`EMU_MAX_RATIO)
                                 : credit_sum;
            end

            if (launch) begin
                flit_cnt <= (entry_i.pck_size > 1) ? entry_i.pck_size - 1'b1 : '0;
            end else if (busy) begin
                flit_cnt <= flit_cnt - 1'b1;
            end
        end
    end

    // a multi flit packet keeps the next head off the following cycle
    a_no_launch_busy: assert property (@(posedge clk) disable iff (reset)
        (pck_valid_o && (pck_o.pck_size > 1)) |=> !pck_valid_o);

endmodule

// File: traffic_gen/latency_stats.sv
// endpoint traffic statistics
`timescale 1ns/1ps
`include "emu_config.svh"

module latency_stats (
    input  logic                     clk,
    input  logic                     reset,
    input  logic                     start_i,
    input  logic                     pck_sent_i,
    input  logic                     dlv_valid_i,
    input  logic [`EMU_TIME_W-1:0]   dlv_stamp_i,
    input  logic [`EMU_TIME_W-1:0]   time_i,
    input  emu_pkg::stat_id_e        stat_id_i,
    output logic [`EMU_STAT_W-1:0]   stat_q_o
);

    logic [`EMU_STAT_W-1:0] sent_cnt;
    logic [`EMU_STAT_W-1:0] rcvd_cnt;
    logic [`EMU_STAT_W-1:0] total_lat;
    logic [`EMU_STAT_W-1:0] worst_lat;
    logic [`EMU_TIME_W-1:0] lat;
    logic [`EMU_STAT_W-1:0] lat_ext;

    assign lat     = time_i - dlv_stamp_i;   // wraps cleanly with the counter
    assign lat_ext = `EMU_STAT_W'(lat);

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            sent_cnt  <= '0;
            rcvd_cnt  <= '0;
            total_lat <= '0;
            worst_lat <= '0;
        end else if (start_i) begin
            sent_cnt  <= '0;   // fresh run
            rcvd_cnt  <= '0;
            total_lat <= '0;
            worst_lat <= '0;
        end else begin
            if (pck_sent_i) sent_cnt <= sent_cnt + 1'b1;
            if (dlv_valid_i) begin
                rcvd_cnt  <= rcvd_cnt + 1'b1;
                total_lat <= total_lat + lat_ext;
                if (lat_ext > worst_lat) worst_lat <= lat_ext;
            end
        end
    end

    always_comb begin
        case (stat_id_i)
            emu_pkg::STAT_SENT:      stat_q_o = sent_cnt;
            emu_pkg::STAT_RCVD:      stat_q_o = rcvd_cnt;
            emu_pkg::STAT_TOTAL_LAT: stat_q_o = total_lat;
            default:                 stat_q_o = worst_lat;
        endcase
    end

endmodule

// File: traffic_gen/traffic_endpoint.sv
// single traffic endpoint
`timescale 1ns/1ps
`include "emu_config.svh"

module traffic_endpoint (
    input  logic                     clk,
    input  logic                     reset,
    input  logic [`EMU_EA_W-1:0]     ep_addr_i,
    input  logic                     host_we_i,
    input  emu_pkg::host_wr_t        host_wr_i,
    input  logic                     start_i,
    input  logic                     dlv_valid_i,
    input  emu_pkg::delivery_t       dlv_i,
    input  emu_pkg::stat_id_e        stat_id_i,
    output logic                     pck_valid_o,
    output emu_pkg::pck_desc_t       pck_o,
    output logic [`EMU_STAT_W-1:0]   stat_q_o,
    output logic                     done_o
);

    localparam int DLY_W = $clog2(`EMU_START_DELAY + 1);

    logic [DLY_W-1:0]         dly_cnt;
    logic                     seq_start;
    logic [`EMU_TIME_W-1:0]   time_cnt;
    logic [`EMU_RAM_AW-1:0]   rd_addr;
    emu_pkg::pattern_entry_t  rd_data;
    emu_pkg::pattern_entry_t  entry;
    logic                     inject_en;
    logic                     stop;
    logic                     pck_sent;

    assign seq_start = (dly_cnt == DLY_W'(`EMU_START_DELAY));

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            dly_cnt  <= '0;
            time_cnt <= '0;
        end else begin
            time_cnt <= time_cnt + 1'b1;  // same value in every endpoint
            if (start_i) dly_cnt <= DLY_W'(1);
            else if (dly_cnt != '0 && !seq_start) dly_cnt <= dly_cnt + 1'b1;
            else dly_cnt <= '0;
        end
    end

    pattern_ram ram_i (.clk(clk), .wr_en_i(host_we_i), .wr_addr_i(host_wr_i.addr),
        .wr_data_i(host_wr_i.data), .rd_addr_i(rd_addr), .rd_data_o(rd_data));

    pattern_sequencer seq_i (.clk(clk), .reset(reset), .start_i(seq_start),
        .ep_addr_i(ep_addr_i), .rd_addr_o(rd_addr), .entry_i(rd_data),
        .pck_sent_i(pck_sent), .inject_en_o(inject_en), .entry_o(entry),
        .stop_o(stop), .done_o(done_o));

    packet_injector inj_i (.clk(clk), .reset(reset), .ep_addr_i(ep_addr_i),
        .inject_en_i(inject_en), .stop_i(stop), .entry_i(entry), .time_i(time_cnt),
        .pck_valid_o(pck_valid_o), .pck_o(pck_o), .pck_sent_o(pck_sent));

    latency_stats stats_i (.clk(clk), .reset(reset), .start_i(seq_start),
        .pck_sent_i(pck_sent), .dlv_valid_i(dlv_valid_i), .dlv_stamp_i(dlv_i.time_stamp),
        .time_i(time_cnt), .stat_id_i(stat_id_i), .stat_q_o(stat_q_o));

endmodule

// File: verilog/noc_emulator.sv
// NoC traffic emulator top
`timescale 1ns/1ps
`include "emu_config.svh"

module noc_emulator (
    input  logic                     clk,
    input  logic                     reset,
    input  logic                     host_we_i,
    input  emu_pkg::host_wr_t        host_wr_i,
    input  logic                     start_i,
    input  logic                     dlv_valid_i,
    input  emu_pkg::delivery_t       dlv_i,
    input  emu_pkg::stat_sel_t       stat_sel_i,
    output logic [`EMU_NE-1:0]       pck_valid_o,
    output emu_pkg::pck_desc_t       pck_o [`EMU_NE],
    output logic [`EMU_STAT_W-1:0]   stat_q_o,
    output logic                     done_o
);

    logic [`EMU_NE-1:0]     ep_we;
    logic [`EMU_NE-1:0]     ep_dlv;
    logic [`EMU_NE-1:0]     ep_done;
    logic [`EMU_STAT_W-1:0] ep_stat [`EMU_NE];
    logic [`EMU_STAT_W-1:0] in_flight;   // launched but not yet delivered

    for (genvar i = 0; i < `EMU_NE; i++) begin : g_ep
        assign ep_we[i]  = host_we_i && (host_wr_i.ep == `EMU_EA_W'(i));
        assign ep_dlv[i] = dlv_valid_i && (dlv_i.dest == `EMU_EA_W'(i));

        traffic_endpoint ep_i (
            .clk        (clk),
            .reset      (reset),
            .ep_addr_i  (`EMU_EA_W'(i)),
            .host_we_i  (ep_we[i]),
            .host_wr_i  (host_wr_i),
            .start_i    (start_i),
            .dlv_valid_i(ep_dlv[i]),
            .dlv_i      (dlv_i),
            .stat_id_i  (stat_sel_i.stat_id),
            .pck_valid_o(pck_valid_o[i]),
            .pck_o      (pck_o[i]),
            .stat_q_o   (ep_stat[i]),
            .done_o     (ep_done[i])
        );
    end

    assign stat_q_o = ep_stat[stat_sel_i.ep];
    assign done_o   = &ep_done;

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            in_flight <= '0;
        end else begin
            in_flight <= in_flight + `EMU_STAT_W'($countones(pck_valid_o))
                         - `EMU_STAT_W'(dlv_valid_i);
        end
    end

    // network cannot deliver more packets than the endpoints launched
    a_rcvd_le_sent: assert property (@(posedge clk) disable iff (reset)
        dlv_valid_i |-> (in_flight != '0));

endmodule

// File: testbench/tb_noc_emulator.sv
// NoC emulator testbench
`timescale 1ns/1ps
`include "emu_config.svh"

module tb_noc_emulator;

    logic                     clk;
    logic                     reset;
    logic                     host_we_i;
    emu_pkg::host_wr_t        host_wr_i;
    logic                     start_i;
    logic                     dlv_valid_i;
    emu_pkg::delivery_t       dlv_i;
    emu_pkg::stat_sel_t       stat_sel_i;
    logic [`EMU_NE-1:0]       pck_valid_o;
    emu_pkg::pck_desc_t       pck_o [`EMU_NE];
    logic [`EMU_STAT_W-1:0]   stat_q_o;
    logic                     done_o;

    // network model state
    int                       ncyc;
    int                       pending;      // scheduled, not yet delivered
    logic [`EMU_EA_W-1:0]     due_dest [int];
    logic [`EMU_TIME_W-1:0]   due_stamp [int];
    emu_pkg::pck_desc_t       desc_log [$];
    int                       desc_cyc [$];
    int                       rcv_cnt [`EMU_NE];
    int                       lat_sum [`EMU_NE];
    int                       lat_max [`EMU_NE];
    int                       errors;
    int                       tests;
    int                       failed_tests;
    bit                       timed_out;

    noc_emulator dut_i (.*);

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // descriptors sampled at negedge, deliveries driven on the next posedge
    initial begin : network_model
        int d;
        logic nxt_v;
        emu_pkg::delivery_t nxt;
        dlv_valid_i = 1'b0;
        dlv_i = '0;
        forever begin
            @(negedge clk);
            ncyc++;
            for (int e = 0; e < `EMU_NE; e++) begin
                if (pck_valid_o[e] === 1'b1) begin
                    desc_log.push_back(pck_o[e]);
                    desc_cyc.push_back(ncyc);
                    d = 1 + int'($urandom % 20);
                    while (due_dest.exists(ncyc + d)) d++;  // one delivery per cycle
                    due_dest[ncyc + d] = pck_o[e].dest;
                    due_stamp[ncyc + d] = pck_o[e].time_stamp;
                    rcv_cnt[pck_o[e].dest] += 1;
                    lat_sum[pck_o[e].dest] += d;
                    if (d > lat_max[pck_o[e].dest]) lat_max[pck_o[e].dest] = d;
                    pending++;
                end
            end
            nxt_v = due_dest.exists(ncyc + 1);
            nxt = '0;
            if (nxt_v) begin
                nxt.dest = due_dest[ncyc + 1];
                nxt.time_stamp = due_stamp[ncyc + 1];
                due_dest.delete(ncyc + 1);
                due_stamp.delete(ncyc + 1);
            end
            @(posedge clk);
            dlv_valid_i <= nxt_v;
            dlv_i <= nxt;
            if (nxt_v) pending--;
        end
    end

    task automatic report_mismatch(string name, logic [31:0] got, logic [31:0] exp);
        $display("mismatch %s: expected 0x%0h, got 0x%0h", name, exp, got);
        errors++;
    endtask

    task automatic finish_test(string name, int err0);
        tests++;
        if (errors != err0 || timed_out) begin
            failed_tests++;
            $display("%s: FAIL, %0d errors", name, errors - err0);
        end else begin
            $display("%s: ok", name);
        end
    endtask

    task automatic write_word(int ep, int addr, int num, int ratio, int size, int dest,
                              int cls, int last);
        emu_pkg::host_wr_t wr;
        wr.ep = `EMU_EA_W'(ep);
        wr.addr = `EMU_RAM_AW'(addr);
        wr.data.pck_num = `EMU_PCK_CNT_W'(num);
        wr.data.ratio = `EMU_RATIO_W'(ratio);
        wr.data.pck_size = `EMU_PCK_SIZ_W'(size);
        wr.data.dest = `EMU_EA_W'(dest);
        wr.data.pck_class = `EMU_CLASS_W'(cls);
        wr.data.last = (last != 0);
        @(posedge clk);
        host_we_i <= 1'b1;
        host_wr_i <= wr;
        @(posedge clk);
        host_we_i <= 1'b0;
    endtask

    // no repeats, one zero-length last entry
    task automatic load_empty(int ep);
        write_word(ep, 0, 0, 0, 0, 0, 0, 0);
        write_word(ep, 1, 0, 100, 1, (ep + 1) % `EMU_NE, 0, 1);
    endtask

    function automatic bit cond_met(int what);
        case (what)
            0: return done_o === 1'b0;
            1: return done_o === 1'b1;
            default: return pending == 0;
        endcase
    endfunction

    task automatic wait_until(int what, int limit, string what_msg);
        int t;
        t = 0;
        @(negedge clk);
        while (!cond_met(what) && t < limit) begin
            @(negedge clk);
            t++;
        end
        if (!cond_met(what)) begin
            $display("timeout after %0d cycles waiting for %s", limit, what_msg);
            timed_out = 1'b1;
        end
    endtask

    task automatic run_pattern();
        desc_log.delete();
        desc_cyc.delete();
        for (int e = 0; e < `EMU_NE; e++) begin
            rcv_cnt[e] = 0;
            lat_sum[e] = 0;
            lat_max[e] = 0;
        end
        @(posedge clk);
        start_i <= 1'b1;
        @(posedge clk);
        start_i <= 1'b0;
        wait_until(0, 40, "done_o to fall");
        if (!timed_out) wait_until(1, 5000, "done_o to rise");
        if (!timed_out) wait_until(2, 200, "the network to drain");
    endtask

    task automatic read_stat(int ep, emu_pkg::stat_id_e id, output logic [31:0] q);
        @(posedge clk);
        stat_sel_i.ep <= `EMU_EA_W'(ep);
        stat_sel_i.stat_id <= id;
        @(negedge clk);
        q = stat_q_o;
    endtask

    task automatic test_reset_state();
        int err0;
        logic [31:0] q;
        err0 = errors;
        @(negedge clk);
        if (done_o !== 1'b0) report_mismatch("done_o", 32'(done_o), 32'd0);
        if (pck_valid_o !== '0) report_mismatch("pck_valid_o", 32'(pck_valid_o), 32'd0);
        for (int e = 0; e < `EMU_NE; e++) begin
            for (int s = 0; s < 4; s++) begin
                read_stat(e, emu_pkg::stat_id_e'(s), q);
                if (q !== '0) report_mismatch($sformatf("stat_q_o ep%0d id%0d", e, s), q, 0);
            end
        end
        finish_test("reset_state", err0);
    endtask

    task automatic test_single_entry();
        int err0;
        logic [31:0] q;
        err0 = errors;
        write_word(0, 0, 0, 0, 0, 0, 0, 0);
        write_word(0, 1, 3, 100, 1, 2, 1, 1);
        for (int e = 1; e < `EMU_NE; e++) load_empty(e);
        run_pattern();
        if (desc_log.size() != 3) report_mismatch("descriptor count", desc_log.size(), 3);
        foreach (desc_log[i]) begin
            if (desc_log[i].src !== 0) report_mismatch("pck_o.src", 32'(desc_log[i].src), 0);
            if (desc_log[i].dest !== 2) report_mismatch("pck_o.dest", 32'(desc_log[i].dest), 2);
            if (desc_log[i].pck_class !== 1)
                report_mismatch("pck_o.pck_class", 32'(desc_log[i].pck_class), 1);
        end
        read_stat(0, emu_pkg::STAT_SENT, q);
        if (q !== 3) report_mismatch("stat_q_o sent ep0", q, 3);
        finish_test("single_entry", err0);
    endtask

    task automatic test_repeat_pass();
        int err0;
        logic [31:0] q;
        err0 = errors;
        write_word(1, 0, 2, 0, 0, 0, 0, 0);       // two extra passes
        write_word(1, 1, 2, 50, 3, 3, 0, 0);
        write_word(1, 2, 4, 50, 3, 0, 2, 1);
        load_empty(0);
        load_empty(2);
        load_empty(3);
        run_pattern();
        if (desc_log.size() != 18) report_mismatch("descriptor count", desc_log.size(), 18);
        foreach (desc_log[i]) begin
            if (desc_log[i].src !== 1) report_mismatch("pck_o.src", 32'(desc_log[i].src), 1);
            if (desc_log[i].pck_size !== 3)
                report_mismatch("pck_o.pck_size", 32'(desc_log[i].pck_size), 3);
            if (i > 0 && desc_cyc[i] - desc_cyc[i - 1] < 3) begin
                $display("packet %0d started before the previous one finished", i);
                errors++;
            end
        end
        read_stat(1, emu_pkg::STAT_SENT, q);
        if (q !== 18) report_mismatch("stat_q_o sent ep1", q, 18);
        finish_test("repeat_pass", err0);
    endtask

    task automatic test_self_skip();
        int err0;
        logic [31:0] q;
        err0 = errors;
        write_word(2, 0, 0, 0, 0, 0, 0, 0);
        write_word(2, 1, 5, 100, 2, 2, 0, 0);     // aimed at itself
        write_word(2, 2, 2, 100, 2, 3, 2, 1);
        load_empty(0);
        load_empty(1);
        load_empty(3);
        run_pattern();
        if (desc_log.size() != 2) report_mismatch("descriptor count", desc_log.size(), 2);
        foreach (desc_log[i]) begin
            if (desc_log[i].dest !== 3) report_mismatch("pck_o.dest", 32'(desc_log[i].dest), 3);
        end
        read_stat(2, emu_pkg::STAT_SENT, q);
        if (q !== 2) report_mismatch("stat_q_o sent ep2", q, 2);
        finish_test("self_skip", err0);
    endtask

    task automatic test_random_traffic();
        int err0;
        int rep;
        int n;
        int num;
        int dest;
        int exp_sent [`EMU_NE];
        logic [31:0] q;
        err0 = errors;
        for (int e = 0; e < `EMU_NE; e++) begin
            rep = $urandom % 2;
            n = 1 + $urandom % 3;
            exp_sent[e] = 0;
            write_word(e, 0, rep, 0, 0, 0, 0, 0);
            for (int k = 1; k <= n; k++) begin
                num = 1 + $urandom % 4;
                dest = $urandom % `EMU_NE;
                if (dest != e) exp_sent[e] += num * (rep + 1);   // self entries are skipped
                write_word(e, k, num, 10 + $urandom % 91, 1 + $urandom % 4, dest,
                           $urandom % 4, (k == n) ? 1 : 0);
            end
        end
        run_pattern();
        for (int e = 0; e < `EMU_NE; e++) begin
            read_stat(e, emu_pkg::STAT_SENT, q);
            if (q !== exp_sent[e])
                report_mismatch($sformatf("sent ep%0d", e), q, exp_sent[e]);
            read_stat(e, emu_pkg::STAT_RCVD, q);
            if (q !== rcv_cnt[e])
                report_mismatch($sformatf("rcvd ep%0d", e), q, rcv_cnt[e]);
            read_stat(e, emu_pkg::STAT_TOTAL_LAT, q);
            if (q !== lat_sum[e])
                report_mismatch($sformatf("total_lat ep%0d", e), q, lat_sum[e]);
            read_stat(e, emu_pkg::STAT_WORST_LAT, q);
            if (q !== lat_max[e])
                report_mismatch($sformatf("worst_lat ep%0d", e), q, lat_max[e]);
        end
        finish_test("random_traffic", err0);
    endtask

    initial begin : main
        errors = 0;
        tests = 0;
        failed_tests = 0;
        timed_out = 1'b0;
        ncyc = 0;
        pending = 0;
        reset = 1'b1;
        host_we_i = 1'b0;
        host_wr_i = '0;
        start_i = 1'b0;
        stat_sel_i = '0;
        void'($urandom(32'h94f2));
        repeat (5) @(posedge clk);
        reset <= 1'b0;
        test_reset_state();
        if (!timed_out) test_single_entry();
        if (!timed_out) test_repeat_pass();
        if (!timed_out) test_self_skip();
        if (!timed_out) test_random_traffic();
        $display("tests run %0d, tests failed %0d, errors %0d", tests, failed_tests, errors);
        if (timed_out || errors != 0 || failed_tests != 0) begin
            $display("Test failed");
        end else begin
            $display("Test completed successfully");
        end
        $finish;
    end

endmodule

// File: files.f
+incdir+common
common/emu_pkg.sv
traffic_gen/pattern_ram.sv
traffic_gen/pattern_sequencer.sv
traffic_gen/packet_injector.sv
traffic_gen/latency_stats.sv
traffic_gen/traffic_endpoint.sv
verilog/noc_emulator.sv
testbench/tb_noc_emulator.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= tb_noc_emulator
RTL_TOP   ?= noc_emulator
FILELIST  ?= files.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0
PASS_MSG  ?= Test completed successfully

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

run: build
	@out=$$(./$(BUILD_DIR)/V$(TOP)); \
	echo "$$out"; \
	echo "$$out" | grep -qF "$(PASS_MSG)"

lint:
	$(VERILATOR) --lint-only --timing --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR)
